//--- logic/palette_pkg.sv
//////////////////////////////
// palette lookup shared types
// widths, lane structs and the
// AXI4-Lite register map
//////////////////////////////

package palette_pkg;

    localparam int IDX_W     = 8;     // colour index width
    localparam int COLOR_W   = 16;    // palette entry, 12-bit rgb in low bits
    localparam int PAL_DEPTH = 256;
    localparam int AXIL_AW   = 12;
    localparam int AXIL_DW   = 32;

    localparam logic [AXIL_AW-1:0] CTRL_ADDR = 12'h000;
    localparam logic [AXIL_AW-1:0] PAL_BASE  = 12'h400;   // window up to 0x7fc

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // one palette write, broadcast to every lane
    typedef struct packed {
        logic               en;
        logic [IDX_W-1:0]   addr;
        logic [COLOR_W-1:0] data;
    } pal_wr_t;

    typedef struct packed {
        logic             valid;
        logic [IDX_W-1:0] idx;
    } lane_idx_t;

    typedef struct packed {
        logic               valid;
        logic [COLOR_W-1:0] color;
    } lane_color_t;

    // decoded target of an AXI access
    typedef enum logic [1:0] {
        REG_CTRL,
        REG_PALETTE,
        REG_NONE
    } reg_sel_e;

endpackage

//--- logic/palette_ram.sv
//////////////////////////////
// palette ram
// 256 x 16 colour memory, one
// write port, registered read,
// loaded with the 16-colour set
//////////////////////////////

module palette_ram (
    input  logic                            clk,
    input  palette_pkg::pal_wr_t            wr_i,
    input  logic                            rd_en_i,
    input  logic [palette_pkg::IDX_W-1:0]   rd_addr_i,
    output logic [palette_pkg::COLOR_W-1:0] rd_data_o
);
    import palette_pkg::*;

    logic [COLOR_W-1:0] mem [PAL_DEPTH];

    initial begin
        mem[0]  = 16'h0000;    // black
        mem[1]  = 16'h000A;    // blue
        mem[2]  = 16'h00A0;    // green
        mem[3]  = 16'h00AA;    // cyan
        mem[4]  = 16'h0A00;    // red
        mem[5]  = 16'h0A0A;    // magenta
        mem[6]  = 16'h0AA0;    // brown
        mem[7]  = 16'h0AAA;    // light grey
        mem[8]  = 16'h0555;    // dark grey
        mem[9]  = 16'h055F;    // light blue
        mem[10] = 16'h05F5;    // light green
        mem[11] = 16'h05FF;    // light cyan
        mem[12] = 16'h0F55;    // light red
        mem[13] = 16'h0F5F;    // light magenta
        mem[14] = 16'h0FF5;    // yellow
        mem[15] = 16'h0FFF;    // white
        for (int i = 16; i < PAL_DEPTH; i++) begin
            mem[i] = 16'h0555;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // same-entry write and read returns the old value
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

//--- logic/palette_regs_axil.sv
//////////////////////////////
// palette register slave
// AXI4-Lite access to the ctrl
// register and palette writes,
// broadcast to all lanes
//////////////////////////////

module palette_regs_axil (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [palette_pkg::AXIL_AW-1:0] s_awaddr_i,
    input  logic                            s_awvalid_i,
    output logic                            s_awready_o,
    input  logic [palette_pkg::AXIL_DW-1:0] s_wdata_i,
    input  logic [3:0]                      s_wstrb_i,
    input  logic                            s_wvalid_i,
    output logic                            s_wready_o,
    output logic [1:0]                      s_bresp_o,
    output logic                            s_bvalid_o,
    input  logic                            s_bready_i,
    input  logic [palette_pkg::AXIL_AW-1:0] s_araddr_i,
    input  logic                            s_arvalid_i,
    output logic                            s_arready_o,
    output logic [palette_pkg::AXIL_DW-1:0] s_rdata_o,
    output logic [1:0]                      s_rresp_o,
    output logic                            s_rvalid_o,
    input  logic                            s_rready_i,
    output palette_pkg::pal_wr_t            pal_wr_o,
    output logic                            blank_o
);
    import palette_pkg::*;

    logic               wr_accept;
    logic               rd_accept;
    logic               strb_full;
    reg_sel_e           wr_sel;
    reg_sel_e           rd_sel;
    logic               bvalid_q;
    logic               rvalid_q;
    logic               blank_q;
    logic               wr_en_q;
    logic [IDX_W-1:0]   wr_addr_q;
    logic [COLOR_W-1:0] wr_data_q;
    logic [1:0]         bresp_q;
    logic [1:0]         rresp_q;
    logic [AXIL_DW-1:0] rdata_q;

    function automatic reg_sel_e decode(input logic [AXIL_AW-1:0] addr);
        reg_sel_e sel;
        if (addr[AXIL_AW-1:2] == CTRL_ADDR[AXIL_AW-1:2]) begin
            sel = REG_CTRL;
        end else if (addr[AXIL_AW-1:10] == PAL_BASE[AXIL_AW-1:10]) begin
            sel = REG_PALETTE;
        end else begin
            sel = REG_NONE;
        end
        return sel;
    endfunction

    assign wr_sel    = decode(s_awaddr_i);
    assign rd_sel    = decode(s_araddr_i);
    assign strb_full = (s_wstrb_i[1:0] == 2'b11);    // 16-bit entry needs both bytes

    // aw and w taken together, one response outstanding
    assign wr_accept   = s_awvalid_i && s_wvalid_i && !bvalid_q;
    assign s_awready_o = wr_accept;
    assign s_wready_o  = wr_accept;
    assign rd_accept   = s_arvalid_i && !rvalid_q;
    assign s_arready_o = !rvalid_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            blank_q  <= 1'b0;
            wr_en_q  <= 1'b0;
        end else begin
            wr_en_q <= wr_accept && (wr_sel == REG_PALETTE) && strb_full;    // one-cycle pulse
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
            if (wr_accept && (wr_sel == REG_CTRL) && s_wstrb_i[0]) begin
                blank_q <= s_wdata_i[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_addr_q <= s_awaddr_i[IDX_W+1:2];    // entry above word offset
            wr_data_q <= s_wdata_i[COLOR_W-1:0];
            bresp_q   <= (wr_sel == REG_PALETTE && !strb_full) ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_accept) begin
            case (rd_sel)
                REG_CTRL: begin
                    rdata_q <= {{(AXIL_DW-1){1'b0}}, blank_q};
                    rresp_q <= RESP_OKAY;
                end
                REG_PALETTE: begin
                    rdata_q <= '0;             // lane read ports belong to pixel path
                    rresp_q <= RESP_SLVERR;
                end
                default: begin
                    rdata_q <= '0;
                    rresp_q <= RESP_OKAY;
                end
            endcase
        end
    end

    assign s_bvalid_o = bvalid_q;
    assign s_bresp_o  = bresp_q;
    assign s_rvalid_o = rvalid_q;
    assign s_rresp_o  = rresp_q;
    assign s_rdata_o  = rdata_q;
    assign blank_o    = blank_q;
    assign pal_wr_o   = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

//--- logic/pixel_unpack.sv
//////////////////////////////
// pixel unpack
// accepts packed index beats
// and splits them into one
// index register per lane
//////////////////////////////

module pixel_unpack #(
    parameter int LANES = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  in_valid_i,
    output logic                                  in_ready_o,
    input  logic [LANES*palette_pkg::IDX_W-1:0]   in_pix_i,
    input  logic                                  advance_i,
    output palette_pkg::lane_idx_t                lane_o [LANES]
);
    import palette_pkg::*;

    logic             valid_q;
    logic [IDX_W-1:0] idx_q [LANES];

    // stage takes a new word whenever the pipe moves
    assign in_ready_o = advance_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (advance_i) begin
            valid_q <= in_valid_i;    // bubble when no input
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            for (int l = 0; l < LANES; l++) begin
                idx_q[l] <= in_pix_i[l*IDX_W +: IDX_W];    // lane 0 in low bits
            end
        end
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_o[l].valid = valid_q;
            lane_o[l].idx   = idx_q[l];
        end
    end

endmodule

//--- logic/palette_lane.sv
//////////////////////////////
// palette lane
// one index to colour lookup
// with a private palette copy
//////////////////////////////

module palette_lane (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     advance_i,
    input  palette_pkg::pal_wr_t     pal_wr_i,
    input  palette_pkg::lane_idx_t   idx_i,
    output palette_pkg::lane_color_t color_o
);
    import palette_pkg::*;

    logic               valid_q;
    logic [COLOR_W-1:0] rd_data;

    palette_ram palette_ram_inst (
        .clk       (clk),
        .wr_i      (pal_wr_i),
        .rd_en_i   (advance_i),    // ram output holds while stalled
        .rd_addr_i (idx_i.idx),
        .rd_data_o (rd_data)
    );

    // valid follows the registered read
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (advance_i) begin
            valid_q <= idx_i.valid;
        end
    end

    assign color_o.valid = valid_q;
    assign color_o.color = rd_data;

endmodule

//--- logic/color_pack.sv
//////////////////////////////
// colour pack
// output register for the lane
// colours, blanking and the
// pipeline advance
//////////////////////////////

module color_pack #(
    parameter int LANES = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  palette_pkg::lane_color_t              lane_i [LANES],
    input  logic                                  blank_i,
    output logic                                  advance_o,
    output logic                                  out_valid_o,
    input  logic                                  out_ready_i,
    output logic [LANES*palette_pkg::COLOR_W-1:0] out_color_o
);
    import palette_pkg::*;

    logic                     all_valid;
    logic                     out_valid_q;
    logic [LANES*COLOR_W-1:0] color_q;

    // lanes move in lockstep, so this is a full beat
    always_comb begin
        all_valid = 1'b1;
        for (int l = 0; l < LANES; l++) begin
            all_valid = all_valid & lane_i[l].valid;
        end
    end

    // empty or being drained
    assign advance_o = !out_valid_q || out_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (advance_o) begin
            out_valid_q <= all_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            for (int l = 0; l < LANES; l++) begin
                // blank sampled as the beat is registered
                color_q[l*COLOR_W +: COLOR_W] <= blank_i ? '0 : lane_i[l].color;
            end
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_color_o = color_q;

endmodule

//--- logic/palette_top.sv
//////////////////////////////
// palette lookup top
// register slave, unpack, the
// lookup lanes and pack
//////////////////////////////

module palette_top #(
    parameter int LANES = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic [palette_pkg::AXIL_AW-1:0]       s_awaddr_i,
    input  logic                                  s_awvalid_i,
    output logic                                  s_awready_o,
    input  logic [palette_pkg::AXIL_DW-1:0]       s_wdata_i,
    input  logic [3:0]                            s_wstrb_i,
    input  logic                                  s_wvalid_i,
    output logic                                  s_wready_o,
    output logic [1:0]                            s_bresp_o,
    output logic                                  s_bvalid_o,
    input  logic                                  s_bready_i,
    input  logic [palette_pkg::AXIL_AW-1:0]       s_araddr_i,
    input  logic                                  s_arvalid_i,
    output logic                                  s_arready_o,
    output logic [palette_pkg::AXIL_DW-1:0]       s_rdata_o,
    output logic [1:0]                            s_rresp_o,
    output logic                                  s_rvalid_o,
    input  logic                                  s_rready_i,
    input  logic                                  in_valid_i,
    output logic                                  in_ready_o,
    input  logic [LANES*palette_pkg::IDX_W-1:0]   in_pix_i,
    output logic                                  out_valid_o,
    input  logic                                  out_ready_i,
    output logic [LANES*palette_pkg::COLOR_W-1:0] out_color_o
);
    import palette_pkg::*;

    pal_wr_t     pal_wr;
    logic        blank;
    logic        advance;
    lane_idx_t   lane_idx [LANES];
    lane_color_t lane_color [LANES];

    palette_regs_axil palette_regs_axil_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .pal_wr_o    (pal_wr),
        .blank_o     (blank)
    );

    pixel_unpack #(
        .LANES (LANES)
    ) pixel_unpack_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_pix_i   (in_pix_i),
        .advance_i  (advance),
        .lane_o     (lane_idx)
    );

    // each lane owns a palette copy so all look up at once
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        palette_lane palette_lane_inst (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .advance_i (advance),
            .pal_wr_i  (pal_wr),    // same write to every copy
            .idx_i     (lane_idx[l]),
            .color_o   (lane_color[l])
        );
    end

    color_pack #(
        .LANES (LANES)
    ) color_pack_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .lane_i      (lane_color),
        .blank_i     (blank),
        .advance_o   (advance),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_color_o (out_color_o)
    );

endmodule

//--- test/palette_tb.sv
//////////////////////////////
// palette lookup testbench
// random index beats and AXI
// palette traffic, checked
// against a palette model
//////////////////////////////

module palette_tb;
    import palette_pkg::*;

    localparam int LANES       = 4;
    localparam int N_DEFAULT   = 40;
    localparam int N_WRITES    = 16;
    localparam int N_AFTER_WR  = 40;
    localparam int N_BACKPRESS = 60;
    localparam int N_BLANK     = 16;    // per blank setting
    localparam int N_ERR       = 8;
    localparam int TOTAL_BEATS = N_DEFAULT + N_AFTER_WR + N_BACKPRESS + 2 * N_BLANK + N_ERR;
    localparam int AXI_OPS     = N_WRITES + 5;    // ctrl set, read, clear, two error accesses
    localparam int TIMEOUT     = 4 * (TOTAL_BEATS + AXI_OPS) + 200;
    localparam logic [1:0] EXP_OKAY   = 2'd0;
    localparam logic [1:0] EXP_SLVERR = 2'd2;

    logic                     clk = 1'b0;
    logic                     rst_n_i;
    logic [AXIL_AW-1:0]       s_awaddr_i;
    logic                     s_awvalid_i;
    logic                     s_awready_o;
    logic [AXIL_DW-1:0]       s_wdata_i;
    logic [3:0]               s_wstrb_i;
    logic                     s_wvalid_i;
    logic                     s_wready_o;
    logic [1:0]               s_bresp_o;
    logic                     s_bvalid_o;
    logic                     s_bready_i;
    logic [AXIL_AW-1:0]       s_araddr_i;
    logic                     s_arvalid_i;
    logic                     s_arready_o;
    logic [AXIL_DW-1:0]       s_rdata_o;
    logic [1:0]               s_rresp_o;
    logic                     s_rvalid_o;
    logic                     s_rready_i;
    logic                     in_valid_i;
    logic                     in_ready_o;
    logic [LANES*IDX_W-1:0]   in_pix_i;
    logic                     out_valid_o;
    logic                     out_ready_i;
    logic [LANES*COLOR_W-1:0] out_color_o;

    logic [COLOR_W-1:0]       model [PAL_DEPTH];
    logic                     blank_m;
    logic [LANES*COLOR_W-1:0] expected_q [$];
    logic                     in_fire_q = 1'b0;
    string                    test_name;
    int                       seed = 16913;
    int                       cycles = 0;

    palette_top #(
        .LANES (LANES)
    ) palette_top_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_pix_i    (in_pix_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_color_o (out_color_o)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("MISMATCH %s %s: expected 0x%0h, actual 0x%0h",
                                     test_name, what, exp, act));
        end
    endtask

    // 16-colour set, bit 3 selects the bright half
    function automatic logic [COLOR_W-1:0] default_color(input int i);
        logic [3:0] lo;
        logic [3:0] hi;
        lo = i[3] ? 4'h5 : 4'h0;
        hi = i[3] ? 4'hF : 4'hA;
        if (i >= 16) begin
            return 16'h0555;
        end
        return {4'h0, i[2] ? hi : lo, i[1] ? hi : lo, i[0] ? hi : lo};
    endfunction

    function automatic logic [LANES*COLOR_W-1:0] expect_word(input logic [LANES*IDX_W-1:0] pix);
        logic [LANES*COLOR_W-1:0] w;
        for (int l = 0; l < LANES; l++) begin
            w[l*COLOR_W +: COLOR_W] = blank_m ? '0 : model[pix[l*IDX_W +: IDX_W]];
        end
        return w;
    endfunction

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            report_failure($sformatf("timeout after %0d cycles in test %s", cycles, test_name));
        end
    end

    // handshakes seen here take effect at the next rising edge
    always @(negedge clk) begin
        logic [LANES*COLOR_W-1:0] exp_word;
        if (rst_n_i) begin
            in_fire_q = in_valid_i && in_ready_o;
            if (in_fire_q) begin
                expected_q.push_back(expect_word(in_pix_i));
            end
            if (out_valid_o && out_ready_i) begin
                if (expected_q.size() == 0) begin
                    report_failure($sformatf("output beat 0x%h with no beat sent in test %s",
                                             out_color_o, test_name));
                end else begin
                    exp_word = expected_q.pop_front();
                    assert (out_color_o === exp_word) else begin
                        report_failure($sformatf("MISMATCH %s: expected 0x%h, actual 0x%h",
                                                 test_name, exp_word, out_color_o));
                    end
                end
            end
        end
    end

    task automatic send_beats(input int n, input logic stall, input int fixed_idx);
        int                     sent;
        logic [LANES*IDX_W-1:0] pix;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            out_ready_i <= stall ? (($random(seed) & 3) != 0) : 1'b1;
            if (in_fire_q) begin
                sent++;    // current beat taken at this edge
            end
            if (sent == n) begin
                in_valid_i <= 1'b0;
            end else if (in_fire_q || !in_valid_i) begin
                for (int l = 0; l < LANES; l++) begin
                    pix[l*IDX_W +: IDX_W] = (fixed_idx < 0) ? IDX_W'($random(seed))
                                                            : IDX_W'(fixed_idx);
                end
                in_valid_i <= stall ? (($random(seed) & 1) != 0) : 1'b1;
                in_pix_i   <= pix;
            end
        end
    endtask

    task automatic drain();
        @(posedge clk);
        out_ready_i <= 1'b1;
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);    // catch stray beats
    endtask

    task automatic axi_write(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        @(posedge clk);
        s_awaddr_i  <= addr;
        s_awvalid_i <= 1'b1;
        s_wdata_i   <= data;
        s_wstrb_i   <= strb;
        s_wvalid_i  <= 1'b1;
        s_bready_i  <= 1'b1;
        do @(negedge clk); while (!(s_awready_o && s_wready_o));
        @(posedge clk);
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        do @(negedge clk); while (!s_bvalid_o);
        resp = s_bresp_o;
        @(posedge clk);
        s_bready_i <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXIL_AW-1:0] addr, output logic [AXIL_DW-1:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        s_araddr_i  <= addr;
        s_arvalid_i <= 1'b1;
        s_rready_i  <= 1'b1;
        do @(negedge clk); while (!s_arready_o);
        @(posedge clk);
        s_arvalid_i <= 1'b0;
        do @(negedge clk); while (!s_rvalid_o);
        data = s_rdata_o;
        resp = s_rresp_o;
        @(posedge clk);
        s_rready_i <= 1'b0;
    endtask

    initial begin
        logic [1:0]         resp;
        logic [AXIL_DW-1:0] rdata;
        logic [IDX_W-1:0]   entry;
        logic [COLOR_W-1:0] color;
        rst_n_i     <= 1'b0;
        s_awaddr_i  <= '0;
        s_awvalid_i <= 1'b0;
        s_wdata_i   <= '0;
        s_wstrb_i   <= '0;
        s_wvalid_i  <= 1'b0;
        s_bready_i  <= 1'b0;
        s_araddr_i  <= '0;
        s_arvalid_i <= 1'b0;
        s_rready_i  <= 1'b0;
        in_valid_i  <= 1'b0;
        in_pix_i    <= '0;
        out_ready_i <= 1'b0;    // in_ready_o then follows the empty pipe
        blank_m = 1'b0;
        for (int i = 0; i < PAL_DEPTH; i++) begin
            model[i] = default_color(i);
        end

        test_name = "reset state";
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_value("out_valid_o", 0, 32'(out_valid_o));
        check_value("bvalid", 0, 32'(s_bvalid_o));
        check_value("rvalid", 0, 32'(s_rvalid_o));
        check_value("in_ready_o", 1, 32'(in_ready_o));

        test_name = "default palette";
        send_beats(N_DEFAULT, 1'b0, -1);
        drain();

        test_name = "palette writes";
        repeat (N_WRITES) begin
            entry = IDX_W'($random(seed));
            color = COLOR_W'($random(seed));
            axi_write({2'b01, entry, 2'b00}, AXIL_DW'(color), 4'hF, resp);
            check_value("write bresp", 32'(EXP_OKAY), 32'(resp));
            model[entry] = color;
        end
        send_beats(N_AFTER_WR, 1'b0, -1);
        drain();

        test_name = "back-pressure";
        send_beats(N_BACKPRESS, 1'b1, -1);
        drain();

        test_name = "blanking";
        axi_write(12'h000, 32'h1, 4'hF, resp);
        check_value("ctrl bresp", 32'(EXP_OKAY), 32'(resp));
        blank_m = 1'b1;
        axi_read(12'h000, rdata, resp);
        check_value("ctrl rdata", 1, rdata);
        check_value("ctrl rresp", 32'(EXP_OKAY), 32'(resp));
        send_beats(N_BLANK, 1'b0, -1);
        drain();
        axi_write(12'h000, 32'h0, 4'hF, resp);
        check_value("ctrl bresp", 32'(EXP_OKAY), 32'(resp));
        blank_m = 1'b0;
        send_beats(N_BLANK, 1'b0, -1);
        drain();

        test_name = "error responses";
        entry = IDX_W'($random(seed));
        axi_write({2'b01, entry, 2'b00}, AXIL_DW'(~model[entry]), 4'h1, resp);
        check_value("partial strobe bresp", 32'(EXP_SLVERR), 32'(resp));
        send_beats(N_ERR, 1'b0, int'(entry));    // entry must be unchanged
        drain();
        axi_read({2'b01, entry, 2'b00}, rdata, resp);
        check_value("palette rresp", 32'(EXP_SLVERR), 32'(resp));
        check_value("palette rdata", 0, rdata);

        if (expected_q.size() != 0) begin
            report_failure($sformatf("%0d sent beats never came out", expected_q.size()));
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- vlog.f
logic/palette_pkg.sv
logic/palette_ram.sv
logic/palette_regs_axil.sv
logic/pixel_unpack.sv
logic/palette_lane.sv
logic/color_pack.sv
logic/palette_top.sv
test/palette_tb.sv

//--- Makefile
# Verilator build for the palette lookup testbench

VERILATOR ?= verilator
TOP       ?= palette_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
